// File: Makefile
TOP = autotest_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f autotest_top.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f autotest_top.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

// File: autotest_top.f
logic/autotest_pkg.sv
logic/block_buffer.sv
logic/sd_block_reader.sv
logic/test_sequencer.sv
logic/sd_block_writer.sv
logic/autotest_top.sv
dv/autotest_props.sv
dv/autotest_tb.sv

// File: dv/autotest_props.sv
// protocol assertions bound into autotest_top; checks are off while rst is high
module autotest_props #(
  parameter int TIMEOUT_CYCLES = 4096
) (
  input logic        clk,
  input logic        rst,
  input logic        start_uut_i,
  input logic        rst_uut_i,
  input logic        r_block_i,
  input logic        w_block_i,
  input logic        end_uut_i,
  input logic        err_uut_i,
  input logic [31:0] exec_cycles_i
);
  timeunit 1ns;
  timeprecision 1ns;

  start_one_cycle: assert property (@(posedge clk) disable iff (rst)
    start_uut_i |=> !start_uut_i)
    else $error("start_uut_o longer than one cycle");

  strobes_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(r_block_i && w_block_i))
    else $error("read and write block strobes high together");

  // wait holds the UUT out of reset until end, error or the timeout limit
  uut_out_of_reset: assert property (@(posedge clk) disable iff (rst)
    (start_uut_i || (!rst_uut_i && !end_uut_i && !err_uut_i &&
                     (exec_cycles_i + 32'd1 < 32'(TIMEOUT_CYCLES))))
    |=> !rst_uut_i)
    else $error("rst_uut_o high while the wait is running");

endmodule : autotest_props

bind autotest_top autotest_props #(
  .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
) u_props (
  .clk           (clk),
  .rst           (rst),
  .start_uut_i   (start_uut_o),
  .rst_uut_i     (rst_uut_o),
  .r_block_i     (spi_r_block_o),
  .w_block_i     (spi_w_block_o),
  .end_uut_i     (end_uut_i),
  .err_uut_i     (err_uut_i),
  .exec_cycles_i (exec_cycles)
);

// File: dv/autotest_tb.sv
// random self-test of autotest_top with six preset SD blocks; the last block carries a bad signature
module autotest_tb
  import autotest_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ns;

  localparam int          OPERAND_W    = 16;
  localparam int          TIMEOUT      = 40;
  localparam logic [31:0] START_BLOCK  = 32'h100000;
  localparam int          NUM_BLOCKS   = 6;
  localparam int          GOOD_BLOCKS  = 5;
  localparam int          FLAG_OFS     = SIG_BYTES + 2 * (OPERAND_W / 8);
  localparam int          EXEC_OFS     = FLAG_OFS + 1;
  localparam int          QUIET_CYCLES = 200;
  localparam int          MAX_CYCLES   = NUM_BLOCKS * (2 * BLOCK_BYTES * 8 + TIMEOUT + 50) * 2;

  logic                 clk;
  logic                 rst;
  logic                 spi_busy;
  logic [7:0]           spi_data_out;
  logic                 spi_rst;
  logic [31:0]          spi_block_addr;
  logic                 spi_r_block;
  logic                 spi_r_byte;
  logic                 spi_w_block;
  logic                 spi_w_byte;
  logic [7:0]           spi_data_in;
  logic                 busy_uut;
  logic                 end_uut;
  logic                 err_uut;
  logic                 rst_uut;
  logic                 start_uut;
  logic [OPERAND_W-1:0] operand_a;
  logic [OPERAND_W-1:0] operand_b;
  logic [15:0]          err_count;
  logic                 done;

  // SD host model state
  logic [7:0]  blocks [NUM_BLOCKS*BLOCK_BYTES];
  logic [7:0]  written [BLOCK_BYTES];
  logic [7:0]  exp_flag [NUM_BLOCKS];
  int          exp_cnt [NUM_BLOCKS];
  int          busy_left;
  int          act;
  logic        rd_ack;
  logic        wr_ack;
  int          rd_idx;
  int          wr_idx;
  int          cur_blk;
  int          blocks_read;
  int          blocks_written;
  int          exp_errs;

  // UUT model state
  logic        uut_run;
  logic        responded;
  int          uut_cnt;
  int          uut_delay;
  int          busy_tail;

  logic [31:0] lfsr_state;
  int          cycles;
  int          checks;
  int          errors;

  autotest_top #(
    .OPERAND_W      (OPERAND_W),
    .TIMEOUT_CYCLES (TIMEOUT),
    .START_BLOCK    (START_BLOCK)
  ) u_autotest_top (
    .clk              (clk),
    .rst              (rst),
    .spi_busy_i       (spi_busy),
    .spi_data_out_i   (spi_data_out),
    .spi_rst_o        (spi_rst),
    .spi_block_addr_o (spi_block_addr),
    .spi_r_block_o    (spi_r_block),
    .spi_r_byte_o     (spi_r_byte),
    .spi_w_block_o    (spi_w_block),
    .spi_w_byte_o     (spi_w_byte),
    .spi_data_in_o    (spi_data_in),
    .busy_uut_i       (busy_uut),
    .end_uut_i        (end_uut),
    .err_uut_i        (err_uut),
    .rst_uut_o        (rst_uut),
    .start_uut_o      (start_uut),
    .operand_a_o      (operand_a),
    .operand_b_o      (operand_b),
    .err_count_o      (err_count),
    .done_o           (done)
  );

  // galois LFSR, one step per random bit
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) lfsr_state = lfsr_state ^ 32'hA3000000;
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], lfsr_bit()};
    return v;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%0t %s", $time, what);
  endtask

  task automatic finish_run();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  endtask

  // operand A class per block: odd, even, multiple of 5 (no response)
  task automatic fill_blocks();
    logic [15:0] a;
    int          base;
    for (int k = 0; k < NUM_BLOCKS; k++) begin
      base = k * BLOCK_BYTES;
      for (int i = 0; i < BLOCK_BYTES; i++) blocks[base+i] = 8'(rand_bits(8));
      for (int i = 0; i < SIG_BYTES; i++) blocks[base+i] = SIGNATURE[31-8*i -: 8];
      if (k >= GOOD_BLOCKS) blocks[base+3] = blocks[base+3] ^ 8'hFF;
      a = 16'(rand_bits(16));
      case (k % 3)
        0: begin
          a = a | 16'd1;
          if (a % 16'd5 == 16'd0) a = a + 16'd2;
        end
        1: begin
          a = a & 16'hFFFE;
          if (a % 16'd5 == 16'd0) a = a + 16'd2;
        end
        default: a = a - (a % 16'd5);
      endcase
      blocks[base+4] = a[7:0];
      blocks[base+5] = a[15:8];
    end
  endtask

  task automatic check_reset_values();
    check_val("spi_rst_o", 32'(spi_rst), 32'd0);
    check_val("spi_r_block_o", 32'(spi_r_block), 32'd0);
    check_val("spi_r_byte_o", 32'(spi_r_byte), 32'd0);
    check_val("spi_w_block_o", 32'(spi_w_block), 32'd0);
    check_val("spi_w_byte_o", 32'(spi_w_byte), 32'd0);
    check_val("start_uut_o", 32'(start_uut), 32'd0);
    check_val("done_o", 32'(done), 32'd0);
    check_val("rst_uut_o", 32'(rst_uut), 32'd1);
    check_val("err_count_o", 32'(err_count), 32'd0);
  endtask

  task automatic check_written_block();
    int          base;
    logic [7:0]  exp;
    logic [31:0] cnt;
    base = cur_blk * BLOCK_BYTES;
    cnt  = 32'(exp_cnt[cur_blk]);
    for (int i = 0; i < BLOCK_BYTES; i++) begin
      exp = blocks[base+i];
      if (i == FLAG_OFS) exp = exp_flag[cur_blk];
      if (i >= EXEC_OFS && i < EXEC_OFS + EXEC_BYTES) exp = cnt[8*(i-EXEC_OFS) +: 8];
      check_val($sformatf("written byte %0d", i), 32'(written[i]), 32'(exp));
    end
    check_val("err_count_o", 32'(err_count), 32'(exp_errs));
  endtask

  task automatic start_busy(input int a);
    act       = a;
    busy_left = 1 + int'(rand_bits(2));
    spi_busy  = 1'b1;
  endtask

  task automatic host_step();
    if (busy_left > 0) begin
      busy_left--;
      if (busy_left == 0) begin
        spi_busy = 1'b0;
        if (act == 3) begin
          spi_data_out = blocks[cur_blk*BLOCK_BYTES+rd_idx];
          rd_idx++;
          if (rd_idx == BLOCK_BYTES) blocks_read++;
        end else if (act == 5) begin
          written[wr_idx] = spi_data_in;
          wr_idx++;
          if (wr_idx == BLOCK_BYTES) begin
            check_written_block();
            blocks_written++;
          end
        end
        if (act >= 2) check_val("spi_block_addr_o", spi_block_addr, START_BLOCK + 32'(cur_blk));
      end
    end else if (spi_r_byte) begin
      start_busy(3);
    end else if (spi_w_byte) begin
      start_busy(5);
    end else if (spi_r_block && !rd_ack) begin
      rd_ack = 1'b1;
      rd_idx = 0;
      if (blocks_read >= NUM_BLOCKS) begin
        report_failure("read requested beyond the preset blocks");
      end else begin
        cur_blk = blocks_read;
      end
      check_val("spi_block_addr_o", spi_block_addr, START_BLOCK + 32'(blocks_read));
      start_busy(2);
    end else if (spi_w_block && !wr_ack) begin
      wr_ack = 1'b1;
      wr_idx = 0;
      start_busy(4);
    end else if (spi_rst) begin
      start_busy(1);
    end
    if (!spi_r_block) rd_ack = 1'b0;
    if (!spi_w_block) wr_ack = 1'b0;
  endtask

  task automatic uut_step();
    logic [15:0] a;
    logic [15:0] b;
    int          base;
    base = cur_blk * BLOCK_BYTES;
    a    = {blocks[base+5], blocks[base+4]};
    b    = {blocks[base+7], blocks[base+6]};
    if (busy_tail > 0) begin
      busy_tail--;
      if (busy_tail == 0) busy_uut = 1'b0;
    end
    if (start_uut) begin
      check_val("operand_a_o", 32'(operand_a), 32'(a));
      check_val("operand_b_o", 32'(operand_b), 32'(b));
      uut_run   = 1'b1;
      responded = 1'b0;
      uut_cnt   = 0;
      busy_uut  = 1'b1;
      busy_tail = 0;
      if (a % 16'd5 == 16'd0) begin
        uut_delay = 0;
      end else if (a[0]) begin
        uut_delay = 3 + int'(a[2:0]);
      end else begin
        uut_delay = 1 + int'(rand_bits(5)) % 30;
      end
    end else if (uut_run && rst_uut) begin
      // result recorded, UUT back in reset
      uut_run = 1'b0;
      end_uut = 1'b0;
      err_uut = 1'b0;
      busy_tail = 2;
      if (!responded) begin
        exp_flag[cur_blk] = FLAG_TIMEOUT;
        exp_cnt[cur_blk]  = TIMEOUT;
      end
      if (exp_flag[cur_blk] != FLAG_PASS) exp_errs++;
    end else if (uut_run) begin
      uut_cnt++;
      if (!responded && uut_delay != 0 && uut_cnt == uut_delay) begin
        responded        = 1'b1;
        exp_cnt[cur_blk] = uut_cnt;
        if (a[0]) begin
          err_uut           = 1'b1;
          exp_flag[cur_blk] = FLAG_ERR;
        end else begin
          end_uut           = 1'b1;
          exp_flag[cur_blk] = FLAG_PASS;
        end
      end
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      report_failure("timeout, the run did not reach the halt state in time");
      finish_run();
    end
  end

  initial begin
    rst            = 1'b1;
    spi_busy       = 1'b0;
    spi_data_out   = 8'h00;
    busy_uut       = 1'b0;
    end_uut        = 1'b0;
    err_uut        = 1'b0;
    lfsr_state     = 32'h1b36868f;
    cycles         = 0;
    checks         = 0;
    errors         = 0;
    busy_left      = 0;
    act            = 0;
    rd_ack         = 1'b0;
    wr_ack         = 1'b0;
    rd_idx         = 0;
    wr_idx         = 0;
    cur_blk        = 0;
    blocks_read    = 0;
    blocks_written = 0;
    exp_errs       = 0;
    uut_run        = 1'b0;
    responded      = 1'b0;
    uut_cnt        = 0;
    uut_delay      = 0;
    busy_tail      = 0;
    fill_blocks();
    repeat (3) begin
      @(posedge clk);
      #10;
      check_reset_values();
    end
    rst = 1'b0;
    while (!done) begin
      @(posedge clk);
      #10;
      uut_step();
      host_step();
    end
    check_val("blocks read", 32'(blocks_read), 32'(NUM_BLOCKS));
    check_val("blocks written", 32'(blocks_written), 32'(GOOD_BLOCKS));
    // halted for good after the bad signature
    repeat (QUIET_CYCLES) begin
      @(posedge clk);
      #10;
      if (!done) report_failure("done_o dropped after the halt");
      if (spi_rst || spi_r_block || spi_r_byte || spi_w_block || spi_w_byte || start_uut) begin
        report_failure("SD or UUT activity after the halt");
      end
    end
    finish_run();
  end

endmodule : autotest_tb

// File: logic/autotest_pkg.sv
// block layout constants shared by the SD self-test blocks; assumes 512-byte SD blocks only
package autotest_pkg;

  // SD block geometry
  localparam int BLOCK_BYTES = 512;
  localparam int BYTE_IDX_W  = 9;

  // signature at bytes 0..3, most significant byte first
  localparam int          SIG_BYTES = 4;
  localparam logic [31:0] SIGNATURE = 32'hAABBCCDD;

  // execution count field, least significant byte first
  localparam int EXEC_BYTES = 4;

  // result flag codes written back after the operands
  localparam logic [7:0] FLAG_PASS    = 8'd0;
  localparam logic [7:0] FLAG_ERR     = 8'd1;
  localparam logic [7:0] FLAG_TIMEOUT = 8'd2;

endpackage : autotest_pkg

// File: logic/autotest_top.sv
// SD-driven UUT self-test; OPERAND_W must be a multiple of 8 and the operands fit in one block
module autotest_top
  import autotest_pkg::*;
#(
  parameter int          OPERAND_W      = 32,
  parameter int          TIMEOUT_CYCLES = 4096,
  parameter logic [31:0] START_BLOCK    = 32'h100000
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 spi_busy_i,
  input  logic [7:0]           spi_data_out_i,
  output logic                 spi_rst_o,
  output logic [31:0]          spi_block_addr_o,
  output logic                 spi_r_block_o,
  output logic                 spi_r_byte_o,
  output logic                 spi_w_block_o,
  output logic                 spi_w_byte_o,
  output logic [7:0]           spi_data_in_o,
  input  logic                 busy_uut_i,
  input  logic                 end_uut_i,
  input  logic                 err_uut_i,
  output logic                 rst_uut_o,
  output logic                 start_uut_o,
  output logic [OPERAND_W-1:0] operand_a_o,
  output logic [OPERAND_W-1:0] operand_b_o,
  output logic [15:0]          err_count_o,
  output logic                 done_o
);

  logic                  read_start;
  logic                  read_done;
  logic                  write_start;
  logic                  write_done;
  logic                  buf_we;
  logic [BYTE_IDX_W-1:0] buf_waddr;
  logic [7:0]            buf_wdata;
  logic [BYTE_IDX_W-1:0] buf_raddr;
  logic [7:0]            buf_rdata;
  logic [31:0]           signature;
  logic [7:0]            result_flag;
  logic [31:0]           exec_cycles;

  sd_block_reader #(.OPERAND_W(OPERAND_W)) u_reader (
    .clk            (clk),
    .rst            (rst),
    .read_start_i   (read_start),
    .spi_busy_i     (spi_busy_i),
    .spi_data_out_i (spi_data_out_i),
    .spi_r_block_o  (spi_r_block_o),
    .spi_r_byte_o   (spi_r_byte_o),
    .read_done_o    (read_done),
    .buf_we_o       (buf_we),
    .buf_waddr_o    (buf_waddr),
    .buf_wdata_o    (buf_wdata),
    .signature_o    (signature),
    .operand_a_o    (operand_a_o),
    .operand_b_o    (operand_b_o)
  );

  block_buffer u_buffer (
    .clk     (clk),
    .we_i    (buf_we),
    .waddr_i (buf_waddr),
    .wdata_i (buf_wdata),
    .raddr_i (buf_raddr),
    .rdata_o (buf_rdata)
  );

  test_sequencer #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES),
    .START_BLOCK    (START_BLOCK)
  ) u_sequencer (
    .clk              (clk),
    .rst              (rst),
    .spi_busy_i       (spi_busy_i),
    .signature_i      (signature),
    .read_done_i      (read_done),
    .write_done_i     (write_done),
    .busy_uut_i       (busy_uut_i),
    .end_uut_i        (end_uut_i),
    .err_uut_i        (err_uut_i),
    .spi_rst_o        (spi_rst_o),
    .spi_block_addr_o (spi_block_addr_o),
    .read_start_o     (read_start),
    .write_start_o    (write_start),
    .rst_uut_o        (rst_uut_o),
    .start_uut_o      (start_uut_o),
    .result_flag_o    (result_flag),
    .exec_cycles_o    (exec_cycles),
    .err_count_o      (err_count_o),
    .done_o           (done_o)
  );

  sd_block_writer #(.OPERAND_W(OPERAND_W)) u_writer (
    .clk           (clk),
    .rst           (rst),
    .write_start_i (write_start),
    .spi_busy_i    (spi_busy_i),
    .result_flag_i (result_flag),
    .exec_cycles_i (exec_cycles),
    .buf_rdata_i   (buf_rdata),
    .spi_w_block_o (spi_w_block_o),
    .spi_w_byte_o  (spi_w_byte_o),
    .spi_data_in_o (spi_data_in_o),
    .write_done_o  (write_done),
    .buf_raddr_o   (buf_raddr)
  );

endmodule : autotest_top

// File: logic/block_buffer.sv
// 512 x 8 simple dual-port RAM, read data valid one cycle after the address, contents not reset
module block_buffer (
  input  logic       clk,
  input  logic       we_i,
  input  logic [8:0] waddr_i,
  input  logic [7:0] wdata_i,
  input  logic [8:0] raddr_i,
  output logic [7:0] rdata_o
);

  logic [7:0] mem [0:511];

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // registered read port
  always_ff @(posedge clk) begin
    rdata_o <= mem[raddr_i];
  end

endmodule : block_buffer

// File: logic/sd_block_reader.sv
// reads a full SD block into the buffer; OPERAND_W must be a multiple of 8, operands change while reading
module sd_block_reader
  import autotest_pkg::*;
#(
  parameter int OPERAND_W = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  read_start_i,
  input  logic                  spi_busy_i,
  input  logic [7:0]            spi_data_out_i,
  output logic                  spi_r_block_o,
  output logic                  spi_r_byte_o,
  output logic                  read_done_o,
  output logic                  buf_we_o,
  output logic [BYTE_IDX_W-1:0] buf_waddr_o,
  output logic [7:0]            buf_wdata_o,
  output logic [31:0]           signature_o,
  output logic [OPERAND_W-1:0]  operand_a_o,
  output logic [OPERAND_W-1:0]  operand_b_o
);

  localparam int OP_BYTES = OPERAND_W / 8;

  localparam logic [2:0] S_IDLE      = 3'd0;
  localparam logic [2:0] S_BLK_REQ   = 3'd1;
  localparam logic [2:0] S_BLK_WAIT  = 3'd2;
  localparam logic [2:0] S_BYTE_REQ  = 3'd3;
  localparam logic [2:0] S_BYTE_WAIT = 3'd4;

  logic [2:0]            state;
  logic [BYTE_IDX_W-1:0] byte_cnt;
  logic                  byte_in;
  logic                  last_byte;

  // byte arrives in the cycle busy is seen low after the request
  assign byte_in   = (state == S_BYTE_WAIT) && !spi_busy_i;
  assign last_byte = (byte_cnt == BYTE_IDX_W'(BLOCK_BYTES - 1));

  assign spi_r_block_o = (state != S_IDLE);
  assign spi_r_byte_o  = (state == S_BYTE_REQ);
  assign buf_we_o      = byte_in;
  assign buf_waddr_o   = byte_cnt;
  assign buf_wdata_o   = spi_data_out_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= S_IDLE;
      byte_cnt    <= '0;
      read_done_o <= 1'b0;
    end else begin
      read_done_o <= byte_in && last_byte;
      case (state)
        S_IDLE: begin
          byte_cnt <= '0;
          if (read_start_i) state <= S_BLK_REQ;
        end
        S_BLK_REQ:  if (spi_busy_i) state <= S_BLK_WAIT;
        S_BLK_WAIT: if (!spi_busy_i) state <= S_BYTE_REQ;
        S_BYTE_REQ: if (spi_busy_i) state <= S_BYTE_WAIT;
        S_BYTE_WAIT: begin
          if (byte_in) begin
            byte_cnt <= byte_cnt + 1'b1;
            state    <= last_byte ? S_IDLE : S_BYTE_REQ;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // signature and operand capture by byte index
  always_ff @(posedge clk) begin
    if (byte_in) begin
      if (byte_cnt < BYTE_IDX_W'(SIG_BYTES)) begin
        signature_o <= {signature_o[23:0], spi_data_out_i};
      end
      for (int i = 0; i < OP_BYTES; i++) begin
        if (byte_cnt == BYTE_IDX_W'(SIG_BYTES + i)) operand_a_o[8*i +: 8] <= spi_data_out_i;
        if (byte_cnt == BYTE_IDX_W'(SIG_BYTES + OP_BYTES + i)) begin
          operand_b_o[8*i +: 8] <= spi_data_out_i;
        end
      end
    end
  end

endmodule : sd_block_reader

// File: logic/sd_block_writer.sv
// writes the buffered block back to SD with flag and count substituted; OPERAND_W must match the reader
module sd_block_writer
  import autotest_pkg::*;
#(
  parameter int OPERAND_W = 32
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  write_start_i,
  input  logic                  spi_busy_i,
  input  logic [7:0]            result_flag_i,
  input  logic [31:0]           exec_cycles_i,
  input  logic [7:0]            buf_rdata_i,
  output logic                  spi_w_block_o,
  output logic                  spi_w_byte_o,
  output logic [7:0]            spi_data_in_o,
  output logic                  write_done_o,
  output logic [BYTE_IDX_W-1:0] buf_raddr_o
);

  localparam int FLAG_OFS = SIG_BYTES + 2 * (OPERAND_W / 8);
  localparam int EXEC_OFS = FLAG_OFS + 1;

  localparam logic [2:0] S_IDLE      = 3'd0;
  localparam logic [2:0] S_BLK_REQ   = 3'd1;
  localparam logic [2:0] S_BLK_WAIT  = 3'd2;
  localparam logic [2:0] S_FETCH     = 3'd3;
  localparam logic [2:0] S_LOAD      = 3'd4;
  localparam logic [2:0] S_BYTE_REQ  = 3'd5;
  localparam logic [2:0] S_BYTE_WAIT = 3'd6;

  logic [2:0]            state;
  logic [BYTE_IDX_W-1:0] byte_cnt;
  logic                  byte_out;
  logic                  last_byte;

  assign byte_out  = (state == S_BYTE_WAIT) && !spi_busy_i;
  assign last_byte = (byte_cnt == BYTE_IDX_W'(BLOCK_BYTES - 1));

  assign spi_w_block_o = (state != S_IDLE);
  assign spi_w_byte_o  = (state == S_BYTE_REQ);
  assign buf_raddr_o   = byte_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= S_IDLE;
      byte_cnt     <= '0;
      write_done_o <= 1'b0;
    end else begin
      write_done_o <= byte_out && last_byte;
      case (state)
        S_IDLE: begin
          byte_cnt <= '0;
          if (write_start_i) state <= S_BLK_REQ;
        end
        S_BLK_REQ:  if (spi_busy_i) state <= S_BLK_WAIT;
        S_BLK_WAIT: if (!spi_busy_i) state <= S_FETCH;
        // address out in fetch, RAM data valid in load
        S_FETCH:    state <= S_LOAD;
        S_LOAD:     state <= S_BYTE_REQ;
        S_BYTE_REQ: if (spi_busy_i) state <= S_BYTE_WAIT;
        S_BYTE_WAIT: begin
          if (byte_out) begin
            byte_cnt <= byte_cnt + 1'b1;
            state    <= last_byte ? S_IDLE : S_FETCH;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // outgoing byte, held until busy falls
  always_ff @(posedge clk) begin
    if (state == S_LOAD) begin
      spi_data_in_o <= buf_rdata_i;
      if (byte_cnt == BYTE_IDX_W'(FLAG_OFS)) spi_data_in_o <= result_flag_i;
      for (int i = 0; i < EXEC_BYTES; i++) begin
        if (byte_cnt == BYTE_IDX_W'(EXEC_OFS + i)) spi_data_in_o <= exec_cycles_i[8*i +: 8];
      end
    end
  end

endmodule : sd_block_writer

// File: logic/test_sequencer.sv
// phase FSM for one block at a time; a bad signature halts for good until rst, error count saturates
module test_sequencer
  import autotest_pkg::*;
#(
  parameter int          TIMEOUT_CYCLES = 4096,
  parameter logic [31:0] START_BLOCK    = 32'h100000
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        spi_busy_i,
  input  logic [31:0] signature_i,
  input  logic        read_done_i,
  input  logic        write_done_i,
  input  logic        busy_uut_i,
  input  logic        end_uut_i,
  input  logic        err_uut_i,
  output logic        spi_rst_o,
  output logic [31:0] spi_block_addr_o,
  output logic        read_start_o,
  output logic        write_start_o,
  output logic        rst_uut_o,
  output logic        start_uut_o,
  output logic [7:0]  result_flag_o,
  output logic [31:0] exec_cycles_o,
  output logic [15:0] err_count_o,
  output logic        done_o
);

  localparam logic [3:0] S_INIT       = 4'd0;
  localparam logic [3:0] S_SD_RST     = 4'd1;
  localparam logic [3:0] S_SD_WAIT    = 4'd2;
  localparam logic [3:0] S_READ_GO    = 4'd3;
  localparam logic [3:0] S_READ_WAIT  = 4'd4;
  localparam logic [3:0] S_CHECK      = 4'd5;
  localparam logic [3:0] S_START      = 4'd6;
  localparam logic [3:0] S_RUN        = 4'd7;
  localparam logic [3:0] S_RECOVER    = 4'd8;
  localparam logic [3:0] S_WRITE_GO   = 4'd9;
  localparam logic [3:0] S_WRITE_WAIT = 4'd10;
  localparam logic [3:0] S_ADVANCE    = 4'd11;
  localparam logic [3:0] S_HALT       = 4'd12;

  logic [3:0]  state;
  logic        write_phase;
  logic [31:0] timer_nxt;
  logic        run_finish;
  logic [7:0]  run_flag;

  assign timer_nxt = exec_cycles_o + 32'd1;

  // error beats end, both beat the timeout
  always_comb begin
    run_finish = 1'b1;
    run_flag   = FLAG_TIMEOUT;
    if (err_uut_i) begin
      run_flag = FLAG_ERR;
    end else if (end_uut_i) begin
      run_flag = FLAG_PASS;
    end else if (timer_nxt != 32'(TIMEOUT_CYCLES)) begin
      run_finish = 1'b0;
    end
  end

  assign spi_rst_o     = (state == S_SD_RST);
  assign read_start_o  = (state == S_READ_GO);
  assign write_start_o = (state == S_WRITE_GO);
  assign start_uut_o   = (state == S_START);
  assign rst_uut_o     = !((state == S_START) || (state == S_RUN));
  assign done_o        = (state == S_HALT);

  always_ff @(posedge clk) begin
    if (rst) begin
      state            <= S_INIT;
      write_phase      <= 1'b0;
      spi_block_addr_o <= START_BLOCK;
      err_count_o      <= '0;
    end else begin
      case (state)
        S_INIT:      state <= S_SD_RST;
        S_SD_RST:    if (spi_busy_i) state <= S_SD_WAIT;
        S_SD_WAIT: begin
          if (!spi_busy_i) state <= write_phase ? S_WRITE_GO : S_READ_GO;
        end
        S_READ_GO:   state <= S_READ_WAIT;
        S_READ_WAIT: if (read_done_i) state <= S_CHECK;
        S_CHECK:     state <= (signature_i == SIGNATURE) ? S_START : S_HALT;
        S_START:     state <= S_RUN;
        S_RUN: begin
          if (run_finish) begin
            state <= S_RECOVER;
            if (run_flag != FLAG_PASS && err_count_o != '1) begin
              err_count_o <= err_count_o + 1'b1;
            end
          end
        end
        S_RECOVER: begin
          // UUT stays in reset until it drops busy
          if (!busy_uut_i) begin
            write_phase <= 1'b1;
            state       <= S_SD_RST;
          end
        end
        S_WRITE_GO:   state <= S_WRITE_WAIT;
        S_WRITE_WAIT: if (write_done_i) state <= S_ADVANCE;
        S_ADVANCE: begin
          spi_block_addr_o <= spi_block_addr_o + 32'd1;
          write_phase      <= 1'b0;
          state            <= S_SD_RST;
        end
        S_HALT:  state <= S_HALT;
        default: state <= S_INIT;
      endcase
    end
  end

  // execution timer doubles as the recorded count
  always_ff @(posedge clk) begin
    if (state == S_START) begin
      exec_cycles_o <= '0;
    end else if (state == S_RUN) begin
      exec_cycles_o <= timer_nxt;
      if (run_finish) result_flag_o <= run_flag;
    end
  end

endmodule : test_sequencer
